/* src/bus_pkg.sv */
// Bus package with the address, data and byte-enable widths and types of the demo bus
package bus_pkg;

  // Word-wide bus with one enable per byte lane
  localparam int BusAddrWidth = 32;
  localparam int BusDataWidth = 32;
  localparam int BusBeWidth   = BusDataWidth / 8;

  // Byte address as issued by the host
  typedef logic [BusAddrWidth-1:0] bus_addr_t;

  // Read and write data word
  typedef logic [BusDataWidth-1:0] bus_data_t;

  // One bit per byte lane, bit 0 covers data[7:0]
  typedef logic [BusBeWidth-1:0]   bus_be_t;

endpackage

/* src/mem_map_pkg.sv */
// Memory map package with the device list, address windows, register offsets and I/O widths
package mem_map_pkg;

  // Decoder selection, DevNone marks an unmapped access
  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2,
    DevNone  = 2'd3
  } bus_device_e;

  // Address windows, each base aligned to its size
  localparam bus_pkg::bus_addr_t RamStart   = 32'h0010_0000;
  localparam bus_pkg::bus_addr_t RamSize    = 32'h0000_1000;  // 4 KiB
  localparam bus_pkg::bus_addr_t RamMask    = ~(RamSize - 1);

  localparam bus_pkg::bus_addr_t GpioStart  = 32'h8000_0000;
  localparam bus_pkg::bus_addr_t GpioSize   = 32'h0000_1000;  // 4 KiB
  localparam bus_pkg::bus_addr_t GpioMask   = ~(GpioSize - 1);

  localparam bus_pkg::bus_addr_t TimerStart = 32'h8000_2000;
  localparam bus_pkg::bus_addr_t TimerSize  = 32'h0000_1000;  // 4 KiB
  localparam bus_pkg::bus_addr_t TimerMask  = ~(TimerSize - 1);

  // RAM depth in words
  localparam int RamWords = 1024;

  // GPIO pin counts
  localparam int GpiWidth = 8;
  localparam int GpoWidth = 16;

  // GPIO register offsets within the window
  localparam bus_pkg::bus_addr_t GpioOutOffset = 32'h0;
  localparam bus_pkg::bus_addr_t GpioInOffset  = 32'h4;

  // Timer register offsets, 64-bit registers split in two words
  localparam bus_pkg::bus_addr_t TimerMtimeLoOffset = 32'h0;
  localparam bus_pkg::bus_addr_t TimerMtimeHiOffset = 32'h4;
  localparam bus_pkg::bus_addr_t TimerCmpLoOffset   = 32'h8;
  localparam bus_pkg::bus_addr_t TimerCmpHiOffset   = 32'hC;

endpackage

/* src/bus_decoder.sv */
// Bus decoder that selects a device by base and mask and returns its registered response
`timescale 1ns/1ps

module bus_decoder (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  // Host side
  input  logic               host_req_i,
  input  bus_pkg::bus_addr_t host_addr_i,
  input  logic               host_we_i,
  input  bus_pkg::bus_be_t   host_be_i,
  input  bus_pkg::bus_data_t host_wdata_i,
  output logic               host_gnt_o,
  output logic               host_rvalid_o,
  output bus_pkg::bus_data_t host_rdata_o,
  output logic               host_err_o,

  // Device side
  output logic               ram_req_o,
  output logic               gpio_req_o,
  output logic               timer_req_o,
  output bus_pkg::bus_addr_t dev_addr_o,
  output logic               dev_we_o,
  output bus_pkg::bus_be_t   dev_be_o,
  output bus_pkg::bus_data_t dev_wdata_o,
  input  bus_pkg::bus_data_t ram_rdata_i,
  input  bus_pkg::bus_data_t gpio_rdata_i,
  input  bus_pkg::bus_data_t timer_rdata_i
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  bus_device_e dev_sel;    // Device hit by the current request
  bus_device_e dev_sel_q;  // Device that owes the next response
  logic        rvalid_q;
  logic        read_q;     // Response carries read data
  bus_data_t   dev_rdata;

  // Windows do not overlap, so the order of the checks is free
  always_comb begin
    if ((host_addr_i & RamMask) == RamStart) begin
      dev_sel = DevRam;
    end else if ((host_addr_i & GpioMask) == GpioStart) begin
      dev_sel = DevGpio;
    end else if ((host_addr_i & TimerMask) == TimerStart) begin
      dev_sel = DevTimer;
    end else begin
      dev_sel = DevNone;
    end
  end

  assign host_gnt_o = host_req_i;  // Single host, never stalls

  assign ram_req_o   = host_req_i & (dev_sel == DevRam);
  assign gpio_req_o  = host_req_i & (dev_sel == DevGpio);
  assign timer_req_o = host_req_i & (dev_sel == DevTimer);

  // Request fields are shared by all devices
  assign dev_addr_o  = host_addr_i;
  assign dev_we_o    = host_we_i;
  assign dev_be_o    = host_be_i;
  assign dev_wdata_o = host_wdata_i;

  // Every device answers one cycle after its strobe
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q  <= 1'b0;
      read_q    <= 1'b0;
      dev_sel_q <= DevNone;
    end else begin
      rvalid_q <= host_req_i;
      if (host_req_i) begin
        read_q    <= ~host_we_i;
        dev_sel_q <= dev_sel;
      end
    end
  end

  always_comb begin
    case (dev_sel_q)
      DevRam:   dev_rdata = ram_rdata_i;
      DevGpio:  dev_rdata = gpio_rdata_i;
      DevTimer: dev_rdata = timer_rdata_i;
      default:  dev_rdata = '0;  // Unmapped reads return zero
    endcase
  end

  assign host_rvalid_o = rvalid_q;
  assign host_rdata_o  = (rvalid_q && read_q) ? dev_rdata : '0;  // Writes answer with zero
  assign host_err_o    = rvalid_q & (dev_sel_q == DevNone);

endmodule

/* src/ram_1p.sv */
// Single-port word RAM with byte-enabled writes and one cycle read latency
`timescale 1ns/1ps

module ram_1p #(
  parameter int Depth = mem_map_pkg::RamWords
) (
  input  logic               clk_sys_i,
  input  logic               req_i,
  input  logic               we_i,
  input  bus_pkg::bus_be_t   be_i,
  input  bus_pkg::bus_addr_t addr_i,
  input  bus_pkg::bus_data_t wdata_i,
  output bus_pkg::bus_data_t rdata_o
);
  import bus_pkg::*;

  bus_data_t                  mem [Depth];
  logic [$clog2(Depth)-1:0]   word_idx;

  // Word index above the byte offset, upper bits wrap around
  assign word_idx = addr_i[2 +: $clog2(Depth)];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < BusBeWidth; i++) begin
          if (be_i[i]) begin
            mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

endmodule

/* src/gpio_regs.sv */
// GPIO block with a byte-writable output register and a synchronized input register
`timescale 1ns/1ps

module gpio_regs (
  input  logic                             clk_sys_i,
  input  logic                             rst_sys_ni,

  input  logic                             req_i,
  input  logic                             we_i,
  input  bus_pkg::bus_be_t                 be_i,
  input  bus_pkg::bus_addr_t               addr_i,
  input  bus_pkg::bus_data_t               wdata_i,
  output bus_pkg::bus_data_t               rdata_o,

  input  logic [mem_map_pkg::GpiWidth-1:0] gp_i,
  output logic [mem_map_pkg::GpoWidth-1:0] gp_o
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  bus_addr_t           reg_off;
  logic [GpiWidth-1:0] gpi_meta;  // First synchronizer stage
  logic [GpiWidth-1:0] gpi_sync;

  assign reg_off = addr_i & ~GpioMask;

  // Output register, updated on the edge that ends the grant cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o <= '0;
    end else if (req_i && we_i && (reg_off == GpioOutOffset)) begin
      for (int i = 0; i < GpoWidth / 8; i++) begin
        if (be_i[i]) begin
          gp_o[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // gp_i comes from pins, two flops before use
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta <= '0;
      gpi_sync <= '0;
    end else begin
      gpi_meta <= gp_i;
      gpi_sync <= gpi_meta;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      case (reg_off)
        GpioOutOffset: rdata_o <= bus_data_t'(gp_o);
        GpioInOffset:  rdata_o <= bus_data_t'(gpi_sync);  // Zero-extended
        default:       rdata_o <= '0;
      endcase
    end
  end

endmodule

/* src/timer_regs.sv */
// Machine timer with free-running mtime, mtimecmp compare register and level interrupt
`timescale 1ns/1ps

module timer_regs (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  input  logic               req_i,
  input  logic               we_i,
  input  bus_pkg::bus_be_t   be_i,
  input  bus_pkg::bus_addr_t addr_i,
  input  bus_pkg::bus_data_t wdata_i,
  output bus_pkg::bus_data_t rdata_o,

  output logic               timer_irq_o
);
  import bus_pkg::*;
  import mem_map_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  bus_addr_t   reg_off;
  logic        wr_en;

  // Replace the enabled byte lanes of one half
  function automatic bus_data_t merge_word(bus_data_t cur, bus_data_t wdata, bus_be_t be);
    bus_data_t res;
    res = cur;
    for (int i = 0; i < BusBeWidth; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign reg_off = addr_i & ~TimerMask;
  assign wr_en   = req_i & we_i;

  // mtime counts every cycle unless software writes it
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime <= '0;
    end else if (wr_en && (reg_off == TimerMtimeLoOffset)) begin
      mtime <= {mtime[63:32], merge_word(mtime[31:0], wdata_i, be_i)};
    end else if (wr_en && (reg_off == TimerMtimeHiOffset)) begin
      mtime <= {merge_word(mtime[63:32], wdata_i, be_i), mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // Starts at all ones so the interrupt stays quiet until armed
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp <= '1;
    end else if (wr_en && (reg_off == TimerCmpLoOffset)) begin
      mtimecmp <= {mtimecmp[63:32], merge_word(mtimecmp[31:0], wdata_i, be_i)};
    end else if (wr_en && (reg_off == TimerCmpHiOffset)) begin
      mtimecmp <= {merge_word(mtimecmp[63:32], wdata_i, be_i), mtimecmp[31:0]};
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      case (reg_off)
        TimerMtimeLoOffset: rdata_o <= mtime[31:0];
        TimerMtimeHiOffset: rdata_o <= mtime[63:32];
        TimerCmpLoOffset:   rdata_o <= mtimecmp[31:0];
        TimerCmpHiOffset:   rdata_o <= mtimecmp[63:32];
        default:            rdata_o <= '0;
      endcase
    end
  end

  // Level interrupt, held until mtimecmp moves past mtime
  assign timer_irq_o = (mtime >= mtimecmp);

endmodule

/* src/demo_bus_top.sv */
// Demo bus top level with the address decoder, word RAM, GPIO and machine timer
`timescale 1ns/1ps

module demo_bus_top (
  input  logic                             clk_sys_i,
  input  logic                             rst_sys_ni,

  // Host port
  input  logic                             host_req_i,
  input  bus_pkg::bus_addr_t               host_addr_i,
  input  logic                             host_we_i,
  input  bus_pkg::bus_be_t                 host_be_i,
  input  bus_pkg::bus_data_t               host_wdata_i,
  output logic                             host_gnt_o,
  output logic                             host_rvalid_o,
  output bus_pkg::bus_data_t               host_rdata_o,
  output logic                             host_err_o,

  // Pins
  input  logic [mem_map_pkg::GpiWidth-1:0] gp_i,
  output logic [mem_map_pkg::GpoWidth-1:0] gp_o,
  output logic                             timer_irq_o
);
  import bus_pkg::*;

  logic      ram_req;
  logic      gpio_req;
  logic      timer_req;
  bus_addr_t dev_addr;
  logic      dev_we;
  bus_be_t   dev_be;
  bus_data_t dev_wdata;
  bus_data_t ram_rdata;
  bus_data_t gpio_rdata;
  bus_data_t timer_rdata;

  bus_decoder u_bus_decoder (
    .clk_sys_i,
    .rst_sys_ni,
    .host_req_i,
    .host_addr_i,
    .host_we_i,
    .host_be_i,
    .host_wdata_i,
    .host_gnt_o,
    .host_rvalid_o,
    .host_rdata_o,
    .host_err_o,
    .ram_req_o    (ram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .dev_addr_o   (dev_addr),
    .dev_we_o     (dev_we),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  ram_1p u_ram (
    .clk_sys_i,
    .req_i  (ram_req),
    .we_i   (dev_we),
    .be_i   (dev_be),
    .addr_i (dev_addr),
    .wdata_i(dev_wdata),
    .rdata_o(ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i  (gpio_req),
    .we_i   (dev_we),
    .be_i   (dev_be),
    .addr_i (dev_addr),
    .wdata_i(dev_wdata),
    .rdata_o(gpio_rdata),
    .gp_i,
    .gp_o
  );

  timer_regs u_timer (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i      (timer_req),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .rdata_o    (timer_rdata),
    .timer_irq_o
  );

endmodule

/* dv/tb_demo_bus.sv */
// Self-checking testbench for the demo bus top level with host driver, reference model and checker
`timescale 1ns/1ps

module tb_demo_bus;
  import bus_pkg::*;
  import mem_map_pkg::*;

  localparam int ResetCycles     = 16;
  localparam int NumRamWords     = 16;
  localparam int NumBurst        = 8;
  localparam int TimerWaitCycles = 60;
  localparam int TimerLead       = 50;
  // RAM, burst, GPIO, unmapped and timer requests in that order
  localparam int NumRequests     = 3 * NumRamWords + 2 * NumBurst + 5 + 3 + 6;
  localparam int TimeoutCycles   = ResetCycles + 4 * NumRequests + TimerWaitCycles + 200;

  logic                clk_sys = 1'b0;
  logic                rst_sys_n;
  logic                host_req;
  bus_addr_t           host_addr;
  logic                host_we;
  bus_be_t             host_be;
  bus_data_t           host_wdata;
  logic                host_gnt;
  logic                host_rvalid;
  bus_data_t           host_rdata;
  logic                host_err;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic                timer_irq;

  // Reference model state
  bus_data_t           shadow_mem [RamWords];
  logic [GpoWidth-1:0] exp_gpo;
  logic [GpiWidth-1:0] last_gpi;
  int                  word_list [NumRamWords];
  logic [31:0]         lfsr_state = 32'hc1d8;
  int                  cycle_cnt = 0;
  bus_data_t           last_rdata;

  // Outstanding responses with the oldest first
  bus_data_t           exp_data_q [$];
  logic                exp_err_q [$];
  logic                chk_data_q [$];
  int                  exp_cycle_q [$];

  demo_bus_top u_demo_bus_top (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .host_req_i   (host_req),
    .host_addr_i  (host_addr),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  initial begin
    forever #50 clk_sys = ~clk_sys;  // 100 ns period
  end

  task automatic stop_failed();
    $display("test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic fail_run(string what);
    $display("Failure at %0t ns: %s", $time, what);
    stop_failed();
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      stop_failed();
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] res;
    logic        fb;
    res = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      res        = {res[30:0], fb};
    end
    return res;
  endfunction

  function automatic bus_data_t merge_bytes(bus_data_t old, bus_data_t wdata, bus_be_t be);
    bus_data_t res;
    res = old;
    for (int i = 0; i < BusBeWidth; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  function automatic logic in_window(bus_addr_t addr, bus_addr_t start, bus_addr_t mask);
    return (addr & mask) == start;
  endfunction

  function automatic bus_addr_t ram_addr(int idx);
    return RamStart + (bus_addr_t'(idx) << 2);
  endfunction

  // Expected {err, rdata} of a request before the model sees it
  function automatic logic [BusDataWidth:0] predict(bus_addr_t addr, logic we);
    bus_data_t data;
    logic      err;
    bus_addr_t off;
    data = '0;
    err  = 1'b0;
    if (in_window(addr, RamStart, RamMask)) begin
      if (!we) data = shadow_mem[addr[2 +: $clog2(RamWords)]];
    end else if (in_window(addr, GpioStart, GpioMask)) begin
      off = addr & ~GpioMask;
      if (!we && off == GpioOutOffset) data = bus_data_t'(exp_gpo);
      if (!we && off == GpioInOffset) data = bus_data_t'(last_gpi);  // Zero-extended pins
    end else if (!in_window(addr, TimerStart, TimerMask)) begin
      err = 1'b1;
    end
    // Timer reads depend on time and are not compared
    return {err, data};
  endfunction

  task automatic update_model(logic we, bus_addr_t addr, bus_be_t be, bus_data_t wdata);
    bus_data_t gpo_word;
    if (we && in_window(addr, RamStart, RamMask)) begin
      shadow_mem[addr[2 +: $clog2(RamWords)]] =
        merge_bytes(shadow_mem[addr[2 +: $clog2(RamWords)]], wdata, be);
    end
    if (we && in_window(addr, GpioStart, GpioMask) && (addr & ~GpioMask) == GpioOutOffset) begin
      gpo_word = merge_bytes(bus_data_t'(exp_gpo), wdata, be);
      exp_gpo  = gpo_word[GpoWidth-1:0];
    end
  endtask

  // Drives one request on the falling edge and checks the grant at the next rising edge
  task automatic issue(logic we, bus_addr_t addr, bus_be_t be, bus_data_t wdata, logic chk);
    logic [BusDataWidth:0] pred;
    @(negedge clk_sys);
    host_req   = 1'b1;
    host_addr  = addr;
    host_we    = we;
    host_be    = be;
    host_wdata = wdata;
    pred = predict(addr, we);
    exp_err_q.push_back(pred[BusDataWidth]);
    exp_data_q.push_back(pred[BusDataWidth-1:0]);
    chk_data_q.push_back(chk);
    exp_cycle_q.push_back(cycle_cnt);
    update_model(we, addr, be, wdata);
    @(posedge clk_sys);
    check_value("host_gnt_o", 1, host_gnt);
  endtask

  task automatic drive_idle();
    @(negedge clk_sys);
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_be    = '0;
    host_wdata = '0;
  endtask

  // Single request that returns once its response has been checked
  task automatic access(logic we, bus_addr_t addr, bus_be_t be, bus_data_t wdata, logic chk);
    issue(we, addr, be, wdata, chk);
    drive_idle();
    @(posedge clk_sys);
  endtask

  task automatic ram_random_rw();
    bus_data_t data;
    bus_be_t   be;
    int        idx;
    for (int i = 0; i < NumRamWords; i++) begin
      word_list[i] = int'(rand_bits($clog2(RamWords)));
      data = rand_bits(BusDataWidth);
      access(1'b1, ram_addr(word_list[i]), 4'hf, data, 1'b1);  // Full word first
    end
    for (int i = 0; i < NumRamWords; i++) begin
      idx  = int'(rand_bits($clog2(NumRamWords)));
      be   = bus_be_t'(rand_bits(BusBeWidth));
      data = rand_bits(BusDataWidth);
      access(1'b1, ram_addr(word_list[idx]), be, data, 1'b1);
    end
    for (int i = 0; i < NumRamWords; i++) begin
      access(1'b0, ram_addr(word_list[i]), '0, '0, 1'b1);
    end
  endtask

  // No idle cycle between any of these requests
  task automatic back_to_back();
    bus_data_t data;
    for (int i = 0; i < NumBurst; i++) begin
      data = rand_bits(BusDataWidth);
      issue(1'b1, ram_addr(RamWords - NumBurst + i), 4'hf, data, 1'b1);
    end
    for (int i = 0; i < NumBurst; i++) begin
      issue(1'b0, ram_addr(RamWords - NumBurst + i), '0, '0, 1'b1);
    end
    drive_idle();
    @(posedge clk_sys);
  endtask

  task automatic gpio_access();
    bus_data_t           data;
    logic [31:0]         bits;
    logic [GpiWidth-1:0] gpi;
    data = rand_bits(BusDataWidth);
    access(1'b1, GpioStart + GpioOutOffset, 4'hf, data, 1'b1);
    check_value("gp_o", exp_gpo, gp_out);
    access(1'b0, GpioStart + GpioOutOffset, '0, '0, 1'b1);
    data = rand_bits(BusDataWidth);
    access(1'b1, GpioStart + GpioOutOffset, 4'b0010, data, 1'b1);  // Upper byte only
    check_value("gp_o", exp_gpo, gp_out);
    access(1'b0, GpioStart + GpioOutOffset, '0, '0, 1'b1);
    bits = rand_bits(GpiWidth);
    gpi  = bits[GpiWidth-1:0];
    if (gpi == last_gpi) begin
      gpi = ~gpi;  // Pins must change
    end
    @(negedge clk_sys);
    gp_in    = gpi;
    last_gpi = gpi;
    repeat (2) @(posedge clk_sys);  // Two synchronizer stages
    access(1'b0, GpioStart + GpioInOffset, '0, '0, 1'b1);
  endtask

  // Aliases RAM word_list[0] if the decode ignored the upper bits
  task automatic unmapped_access();
    bus_addr_t addr;
    bus_data_t data;
    addr = RamStart + RamSize + (bus_addr_t'(word_list[0]) << 2);
    data = rand_bits(BusDataWidth);
    access(1'b1, addr, 4'hf, data, 1'b1);
    access(1'b0, addr, '0, '0, 1'b1);
    access(1'b0, ram_addr(word_list[0]), '0, '0, 1'b1);
  endtask

  task automatic timer_compare();
    bus_data_t t_first;
    bus_data_t t_second;
    int        waited;
    access(1'b0, TimerStart + TimerMtimeLoOffset, '0, '0, 1'b0);
    t_first = last_rdata;
    access(1'b0, TimerStart + TimerMtimeLoOffset, '0, '0, 1'b0);
    t_second = last_rdata;
    check_value("mtime low increasing", 1, t_second > t_first);
    access(1'b1, TimerStart + TimerCmpHiOffset, 4'hf, '0, 1'b1);
    access(1'b1, TimerStart + TimerCmpLoOffset, 4'hf, t_second + TimerLead, 1'b1);
    @(negedge clk_sys);
    check_value("timer_irq_o", 0, timer_irq);
    waited = 0;
    while (!timer_irq && waited < TimerWaitCycles) begin
      @(negedge clk_sys);
      waited++;
    end
    check_value("timer_irq_o", 1, timer_irq);
    access(1'b1, TimerStart + TimerCmpHiOffset, 4'hf, '1, 1'b1);
    access(1'b1, TimerStart + TimerCmpLoOffset, 4'hf, '1, 1'b1);
    @(negedge clk_sys);
    check_value("timer_irq_o", 0, timer_irq);
  endtask

  // Registered outputs are stable at the falling edge
  initial begin
    forever begin
      @(negedge clk_sys);
      if (rst_sys_n === 1'b1 && host_rvalid) begin
        if (exp_data_q.size() == 0) begin
          fail_run("a response arrived with no request outstanding");
        end
        check_value("host_rvalid_o cycle", exp_cycle_q[0] + 1, cycle_cnt);
        check_value("host_err_o", exp_err_q[0], host_err);
        if (chk_data_q[0]) check_value("host_rdata_o", exp_data_q[0], host_rdata);
        last_rdata = host_rdata;
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(chk_data_q.pop_front());
        void'(exp_cycle_q.pop_front());
      end else if (exp_cycle_q.size() != 0 && cycle_cnt >= exp_cycle_q[0] + 1) begin
        fail_run("a granted request got no response on the next cycle");
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk_sys);
      cycle_cnt++;
      if (cycle_cnt > TimeoutCycles) fail_run("the run did not finish within its cycle limit");
    end
  end

  initial begin
    rst_sys_n  = 1'b0;
    host_req   = 1'b0;
    host_addr  = '0;
    host_we    = 1'b0;
    host_be    = '0;
    host_wdata = '0;
    gp_in      = '0;
    last_gpi   = '0;
    exp_gpo    = '0;
    repeat (ResetCycles) @(negedge clk_sys);
    check_value("host_rvalid_o", 0, host_rvalid);
    check_value("host_err_o", 0, host_err);
    check_value("gp_o", 0, gp_out);
    check_value("timer_irq_o", 0, timer_irq);
    rst_sys_n = 1'b1;

    ram_random_rw();
    back_to_back();
    gpio_access();
    unmapped_access();
    timer_compare();

    repeat (3) @(negedge clk_sys);
    if (exp_data_q.size() != 0) begin
      fail_run("requests were still waiting for a response at the end");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* all.f */
src/bus_pkg.sv
src/mem_map_pkg.sv
src/bus_decoder.sv
src/ram_1p.sv
src/gpio_regs.sv
src/timer_regs.sv
src/demo_bus_top.sv
dv/tb_demo_bus.sv
